// File: shift_pkg.sv
`default_nettype none

package shift_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  // Significand width including hidden and guard bits
  localparam int unsigned SIG_W = 26;

  // Shift amount width, wide enough to hold SIG_W itself
  localparam int unsigned AMT_W = 5;

  // Command FIFO depth, a power of two
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Largest effective amount, everything past this is all fill
  localparam logic [AMT_W-1:0] AMT_MAX = AMT_W'(SIG_W);

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_SHR  = 2'd0,  // right align
    OP_SHL  = 2'd1,  // left shift
    OP_NORM = 2'd2   // normalize by leading zeros
  } shift_op_e;

  ////////////////////////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////////////////////////

  // Request from the adder datapath
  typedef struct packed {
    shift_op_e        op;
    logic [SIG_W-1:0] data;
    logic [AMT_W-1:0] amount;
    logic             fill;
  } shift_req_t;

  // Decoded command, amount already saturated at SIG_W
  typedef struct packed {
    logic             dir_left;
    logic [SIG_W-1:0] data;
    logic [AMT_W-1:0] amount;
    logic             fill;
  } shift_cmd_t;

  // Shifter result
  typedef struct packed {
    logic [SIG_W-1:0] data;
    logic             sticky;
    logic [AMT_W-1:0] amount;
  } shift_res_t;

endpackage

`default_nettype wire

// File: shift_request_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module shift_request_decoder import shift_pkg::*; (
  input  wire        clk,
  input  wire        arst_n_i,
  // Request side
  input  wire        req_valid_i,
  input  wire shift_req_t req_i,
  output logic       req_ready_o,
  // Command side
  output logic       cmd_valid_o,
  output shift_cmd_t cmd_o,
  input  wire        cmd_ready_i
);

  logic             req_fire;
  logic [AMT_W-1:0] lzc;
  logic [AMT_W-1:0] eff_amount;
  logic             eff_left;
  logic             eff_fill;

  // Output register is free when empty or drained this cycle
  assign req_ready_o = !cmd_valid_o || cmd_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  ////////////////////////////////////////////////////////////
  // Leading zero count
  ////////////////////////////////////////////////////////////

  // Priority scan from the LSB, the highest set bit wins
  always_comb begin
    lzc = AMT_MAX;
    for (int i = 0; i < SIG_W; i++) begin
      if (req_i.data[i]) begin
        lzc = AMT_W'(SIG_W - 1 - i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    eff_left   = 1'b0;
    eff_fill   = req_i.fill;
    eff_amount = req_i.amount;
    case (req_i.op)
      OP_SHL: begin
        eff_left = 1'b1;
      end
      OP_NORM: begin
        eff_left   = 1'b1;
        eff_fill   = 1'b0;
        eff_amount = lzc;
      end
      default: begin
        eff_left = 1'b0;
      end
    endcase
    // Saturate, anything at or past SIG_W is all fill
    if (eff_amount > AMT_MAX) begin
      eff_amount = AMT_MAX;
    end
  end

  // One-entry output register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      cmd_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      cmd_o.dir_left <= eff_left;
      cmd_o.data     <= req_i.data;
      cmd_o.amount   <= eff_amount;
      cmd_o.fill     <= eff_fill;
    end
  end

endmodule

`default_nettype wire

// File: shift_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module shift_cmd_fifo import shift_pkg::*; (
  input  wire        clk,
  input  wire        arst_n_i,
  // Write side
  input  wire        wr_valid_i,
  input  wire shift_cmd_t wr_cmd_i,
  output logic       wr_ready_o,
  // Read side
  output logic       rd_valid_o,
  output shift_cmd_t rd_cmd_o,
  input  wire        rd_ready_i
);

  shift_cmd_t            mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  full;
  logic                  empty;
  logic                  do_wr;
  logic                  do_rd;

  assign full  = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // A full FIFO still takes a write when the head leaves this cycle
  assign wr_ready_o = !full || rd_ready_i;
  assign rd_valid_o = !empty;
  assign rd_cmd_o   = mem_q[rd_ptr_q];

  assign do_wr = wr_valid_i && wr_ready_o;
  assign do_rd = rd_valid_o && rd_ready_i;

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_cmd_i;
    end
  end

endmodule

`default_nettype wire

// File: barrel_shift_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shift_pipe import shift_pkg::*; (
  input  wire        clk,
  input  wire        arst_n_i,
  // Command side
  input  wire        cmd_valid_i,
  input  wire shift_cmd_t cmd_i,
  output logic       cmd_ready_o,
  // Result side
  output logic       res_valid_o,
  output shift_res_t res_o,
  input  wire        res_ready_i
);

  // Reversal arrays
  logic [SIG_W-1:0] in_rev;
  logic [SIG_W-1:0] out_rev;

  // Right shifter
  logic [SIG_W-1:0] fill_vec;
  logic [SIG_W-1:0] shift_word;
  logic             shift_sticky;

  // Stage 1 registers
  logic             s1_valid_q;
  logic [SIG_W-1:0] s1_word_q;
  logic             s1_sticky_q;
  logic             s1_left_q;
  logic [AMT_W-1:0] s1_amount_q;

  // Stage 2 handshake
  logic             s2_free;
  logic             s1_load;
  logic             s2_load;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Stage 2 moves when empty or when the result is taken
  assign s2_free     = !res_valid_o || res_ready_i;
  assign cmd_ready_o = !s1_valid_q || s2_free;
  assign s1_load     = cmd_valid_i && cmd_ready_o;
  assign s2_load     = s1_valid_q && s2_free;

  ////////////////////////////////////////////////////////////
  // Bit reversal mux arrays
  ////////////////////////////////////////////////////////////

  // Input array flips before the shift, output array flips back
  for (genvar i = 0; i < SIG_W; i++) begin : g_rev
    assign in_rev[i]  = cmd_i.dir_left ? cmd_i.data[SIG_W-1-i] : cmd_i.data[i];
    assign out_rev[i] = s1_left_q ? s1_word_q[SIG_W-1-i] : s1_word_q[i];
  end

  assign fill_vec = {SIG_W{cmd_i.fill}};

  // Log barrel, one level per amount bit, fill enters from the top
  always_comb begin
    shift_word   = in_rev;
    shift_sticky = 1'b0;
    for (int k = 0; k < AMT_W; k++) begin
      logic [SIG_W-1:0] lvl_mask;
      lvl_mask = ~({SIG_W{1'b1}} << (1 << k));
      if (cmd_i.amount[k]) begin
        // Bits falling off the bottom at this level
        shift_sticky = shift_sticky | (|(shift_word & lvl_mask));
        shift_word   = SIG_W'({fill_vec, shift_word} >> (1 << k));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
    end else if (cmd_ready_o) begin
      s1_valid_q <= cmd_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load) begin
      s1_word_q   <= shift_word;
      // Left shifts drop bits at the top, no sticky
      s1_sticky_q <= shift_sticky & ~cmd_i.dir_left;
      s1_left_q   <= cmd_i.dir_left;
      s1_amount_q <= cmd_i.amount;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_o <= 1'b0;
    end else if (s2_free) begin
      res_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_load) begin
      res_o.data   <= out_rev;
      res_o.sticky <= s1_sticky_q;
      res_o.amount <= s1_amount_q;
    end
  end

endmodule

`default_nettype wire

// File: shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_unit import shift_pkg::*; (
  input  wire        clk,
  input  wire        arst_n_i,
  // Requests
  input  wire        req_valid_i,
  input  wire shift_req_t req_i,
  output logic       req_ready_o,
  // Results
  output logic       res_valid_o,
  output shift_res_t res_o,
  input  wire        res_ready_i
);

  // Decoder to FIFO
  logic       dec_valid;
  shift_cmd_t dec_cmd;
  logic       dec_ready;

  // FIFO to shifter
  logic       fifo_valid;
  shift_cmd_t fifo_cmd;
  logic       fifo_ready;

  ////////////////////////////////////////////////////////////
  // Decode, buffer, shift
  ////////////////////////////////////////////////////////////

  shift_request_decoder u_decoder (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .cmd_valid_o (dec_valid),
    .cmd_o       (dec_cmd),
    .cmd_ready_i (dec_ready)
  );

  shift_cmd_fifo u_fifo (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (dec_valid),
    .wr_cmd_i   (dec_cmd),
    .wr_ready_o (dec_ready),
    .rd_valid_o (fifo_valid),
    .rd_cmd_o   (fifo_cmd),
    .rd_ready_i (fifo_ready)
  );

  barrel_shift_pipe u_pipe (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (fifo_valid),
    .cmd_i       (fifo_cmd),
    .cmd_ready_o (fifo_ready),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_ready_i (res_ready_i)
  );

endmodule

`default_nettype wire

// File: tb_shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shift_unit import shift_pkg::*; ();

  localparam int CLK_HALF      = 4;
  localparam int REQ_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int SIG_N         = int'(SIG_W);

  logic       clk;
  logic       arst_n_i;
  logic       req_valid_i;
  shift_req_t req_i;
  logic       req_ready_o;
  logic       res_valid_o;
  shift_res_t res_o;
  logic       res_ready_i;

  integer     seed = 44142;
  int         err_count = 0;
  int         timeout_count = 0;
  int         sent_count = 0;
  int         recv_count = 0;
  bit         abort = 1'b0;
  bit         bp_en = 1'b0;
  shift_res_t exp_q[$];

  shift_unit DUT (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_ready_i (res_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////

  function automatic shift_res_t ref_shift(input shift_req_t req);
    shift_res_t res;
    int         amt;
    int         src;
    bit         left;
    bit         fill;
    bit         found;
    res   = '0;
    amt   = int'(req.amount);
    left  = (req.op != OP_SHR);
    fill  = req.fill;
    found = 1'b0;
    if (req.op == OP_NORM) begin
      fill = 1'b0;
      amt  = 0;
      // Count zeros from the top down to the first one
      for (int i = SIG_N - 1; i >= 0; i--) begin
        if (req.data[i]) begin
          found = 1'b1;
        end else if (!found) begin
          amt++;
        end
      end
    end
    if (amt > SIG_N) begin
      amt = SIG_N;
    end
    for (int i = 0; i < SIG_N; i++) begin
      src = left ? i - amt : i + amt;
      if (src >= 0 && src < SIG_N) begin
        res.data[i] = req.data[src];
      end else begin
        res.data[i] = fill;
      end
    end
    // Bits leaving at the bottom of a right shift
    if (!left) begin
      for (int i = 0; i < amt; i++) begin
        res.sticky = res.sticky | req.data[i];
      end
    end
    res.amount = AMT_W'(amt);
    return res;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic make_req(input shift_op_e op, input bit big_amt, output shift_req_t req);
    req.op     = op;
    req.data   = SIG_W'($random(seed));
    req.amount = AMT_W'($random(seed));
    req.fill   = 1'($random(seed));
    if (big_amt) begin
      req.amount = AMT_W'(SIG_N + int'({$random(seed)} % (32 - SIG_N)));
    end
    // Spread the leading zero count over the whole range
    if (op == OP_NORM) begin
      req.data = req.data >> ({$random(seed)} % (SIG_N + 1));
    end
  endtask

  task automatic send_req(input shift_req_t req);
    int waited;
    bit taken;
    waited = 0;
    taken  = 1'b0;
    @(negedge clk);
    req_valid_i = 1'b1;
    req_i       = req;
    while (!taken && !abort) begin
      #1;
      taken = req_ready_o;
      if (taken) begin
        exp_q.push_back(ref_shift(req));
        sent_count++;
      end
      @(posedge clk);
      if (!taken) begin
        waited++;
        if (waited > REQ_TIMEOUT) begin
          $display("Timeout: request not accepted within %0d cycles", REQ_TIMEOUT);
          timeout_count++;
          abort = 1'b1;
        end else begin
          @(negedge clk);
        end
      end
    end
  endtask

  task automatic stop_req();
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && !abort) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        $display("Timeout: %0d results still outstanding", exp_q.size());
        timeout_count++;
        abort = 1'b1;
      end
    end
  endtask

  // Result side back-pressure
  initial begin
    res_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      if (bp_en) begin
        res_ready_i = 1'($random(seed));
      end else begin
        res_ready_i = 1'b1;
      end
    end
  end

  // Result monitor, transfer happens at the next rising edge
  initial begin : monitor
    shift_res_t exp_r;
    forever begin
      @(negedge clk);
      #1;
      if (arst_n_i && res_valid_o && res_ready_i) begin
        recv_count++;
        if (exp_q.size() == 0) begin
          $display("Error at %0t: result arrived with no request outstanding", $time);
          err_count++;
        end else begin
          exp_r = exp_q.pop_front();
          check_val("res_o.data", 32'(exp_r.data), 32'(res_o.data));
          check_val("res_o.sticky", 32'(exp_r.sticky), 32'(res_o.sticky));
          check_val("res_o.amount", 32'(exp_r.amount), 32'(res_o.amount));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_seq
    shift_req_t req;
    req_valid_i = 1'b0;
    req_i       = '0;
    arst_n_i    = 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_val("res_valid_o", 32'd0, 32'(res_valid_o));
      check_val("req_ready_o", 32'd1, 32'(req_ready_o));
    end
    arst_n_i = 1'b1;
    @(negedge clk);
    check_val("res_valid_o", 32'd0, 32'(res_valid_o));
    check_val("req_ready_o", 32'd1, 32'(req_ready_o));

    // Right alignment, then saturated amounts
    for (int i = 0; i < 40; i++) begin
      make_req(OP_SHR, 1'b0, req);
      send_req(req);
    end
    for (int i = 0; i < 12; i++) begin
      make_req(OP_SHR, 1'b1, req);
      if (i == 0) begin
        req.data = '0;
      end
      send_req(req);
    end
    stop_req();
    wait_drain();

    // Left shift
    for (int i = 0; i < 40; i++) begin
      make_req(OP_SHL, (i % 8) == 0, req);
      send_req(req);
    end
    stop_req();
    wait_drain();

    // Normalize, zero and already normal first
    make_req(OP_NORM, 1'b0, req);
    req.data = '0;
    send_req(req);
    req.data = {1'b1, {(SIG_W - 1){1'b0}}};
    send_req(req);
    for (int i = 0; i < 40; i++) begin
      make_req(OP_NORM, 1'b0, req);
      send_req(req);
    end
    stop_req();
    wait_drain();

    // Mixed burst under random back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < 80; i++) begin
      make_req(shift_op_e'(2'({$random(seed)} % 3)), ({$random(seed)} % 4) == 0, req);
      send_req(req);
    end
    stop_req();
    wait_drain();
    bp_en = 1'b0;

    repeat (10) @(negedge clk);
    check_val("result count", 32'(sent_count), 32'(recv_count));

    $display("Errors: %0d mismatches, %0d timeouts, %0d requests, %0d results",
             err_count, timeout_count, sent_count, recv_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
shift_pkg.sv
shift_request_decoder.sv
shift_cmd_fifo.sv
barrel_shift_pipe.sv
shift_unit.sv
tb_shift_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the shift unit testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log
FAIL_MSG="Done: errors found"
PASS_MSG="Done: no errors"

verilator --binary --timing -j 0 -f list.f --top-module tb_shift_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_shift_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -q "$FAIL_MSG" "$LOG"
if [ $? -eq 0 ]; then
  echo "Simulation failed"
  exit 1
fi

grep -q "$PASS_MSG" "$LOG"
if [ $? -ne 0 ]; then
  echo "Simulation did not run to completion"
  exit 1
fi

echo "Simulation passed"
exit 0
